// File: hdl/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnSlt  = 6'h2a,
		fnSltu = 6'h2b
	} functE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluLui
	} aluOpE;

	typedef enum logic [1:0] {
		fwdReg, // Register file or ID/EX copy
		fwdMem, // ALU result in EX/MEM
		fwdWb   // Writeback value
	} fwdSelE;

	typedef struct packed {
		aluOpE   aluOp;
		logic    useImm;   // Second ALU operand is the immediate
		logic    memRead;
		logic    memWrite;
		logic    regWrite; // Never set for r0
		regAddrT dest;
	} ctrlT;

	typedef struct packed {
		logic    valid;
		wordT    pc;
		ctrlT    ctrl;
		wordT    rsVal;
		wordT    rtVal;
		wordT    imm;
		regAddrT rs;
		regAddrT rt;
	} idExT;

	typedef struct packed {
		logic valid;
		wordT pc;
		ctrlT ctrl;
		wordT aluRes;
		wordT storeData;
	} exMemT;

	typedef struct packed {
		logic    valid;
		wordT    pc;
		logic    regWrite;
		regAddrT dest;
		wordT    result;
	} memWbT;

	// Operand mux shared by decode and execute
	function automatic wordT fwdOperand(fwdSelE sel, wordT regVal, wordT memVal, wordT wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

endpackage

// File: hdl/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	input  logic        wen,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			regs <= '{default: '0};
		else if (wen && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

	// Same-cycle writeback is seen by decode
	assign rdata1 = (raddr1 == 5'd0) ? '0 :
		(wen && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 :
		(wen && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// File: hdl/pipeCtrl.sv
`timescale 1ns/10ps

module pipeCtrl import cpuPkg::*; (
	input  wordT   instrD,
	input  idExT   idEx,
	input  exMemT  exMem,
	input  memWbT  memWb,
	output ctrlT   ctrlD,
	output logic   isBranch,
	output logic   isBne,
	output logic   isJump,
	output fwdSelE fwdRsD,
	output fwdSelE fwdRtD,
	output fwdSelE fwdRsE,
	output fwdSelE fwdRtE,
	output logic   stall
);

	opcodeE  op;
	functE   fn;
	regAddrT rsD;
	regAddrT rtD;
	logic    useRs;
	logic    useRt;
	logic    wrReg;
	logic    toRd;
	logic    hitE;
	logic    hitM;

	// Newest producer wins
	function automatic fwdSelE srcFrom(regAddrT r, exMemT em, memWbT mw);
		if (em.valid && em.ctrl.regWrite && em.ctrl.dest == r)
			return fwdMem;
		if (mw.valid && mw.regWrite && mw.dest == r)
			return fwdWb;
		return fwdReg;
	endfunction

	assign op  = opcodeE'(instrD[31:26]);
	assign fn  = functE'(instrD[5:0]);
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];

	always_comb begin
		ctrlD    = '0;
		wrReg    = 1'b0;
		toRd     = 1'b0;
		useRs    = 1'b0;
		useRt    = 1'b0;
		isBranch = 1'b0;
		isBne    = 1'b0;
		isJump   = 1'b0;
		case (op)
			opSpecial: begin
				wrReg = 1'b1;
				toRd  = 1'b1;
				useRs = 1'b1;
				useRt = 1'b1;
				case (fn)
					fnAddu:  ctrlD.aluOp = aluAdd;
					fnSubu:  ctrlD.aluOp = aluSub;
					fnAnd:   ctrlD.aluOp = aluAnd;
					fnOr:    ctrlD.aluOp = aluOr;
					fnXor:   ctrlD.aluOp = aluXor;
					fnSlt:   ctrlD.aluOp = aluSlt;
					fnSltu:  ctrlD.aluOp = aluSltu;
					default: begin // Unknown funct acts as nop
						wrReg = 1'b0;
						useRs = 1'b0;
						useRt = 1'b0;
					end
				endcase
			end
			opAddiu, opSlti, opAndi, opOri, opLui, opLw: begin
				ctrlD.useImm = 1'b1;
				wrReg        = 1'b1;
				useRs        = (op != opLui);
				case (op)
					opSlti:  ctrlD.aluOp = aluSlt;
					opAndi:  ctrlD.aluOp = aluAnd;
					opOri:   ctrlD.aluOp = aluOr;
					opLui:   ctrlD.aluOp = aluLui;
					default: ctrlD.aluOp = aluAdd;
				endcase
				ctrlD.memRead = (op == opLw);
			end
			opSw: begin
				ctrlD.useImm   = 1'b1;
				ctrlD.memWrite = 1'b1;
				useRs          = 1'b1;
				useRt          = 1'b1;
			end
			opBeq, opBne: begin
				isBranch = 1'b1;
				isBne    = (op == opBne);
				useRs    = 1'b1;
				useRt    = 1'b1;
			end
			opJ:     isJump = 1'b1;
			default: ; // Unknown opcode is a nop
		endcase
		ctrlD.dest     = toRd ? instrD[15:11] : rtD;
		ctrlD.regWrite = wrReg & (ctrlD.dest != '0);
	end

	assign fwdRsD = srcFrom(rsD, exMem, memWb);
	assign fwdRtD = srcFrom(rtD, exMem, memWb);
	assign fwdRsE = srcFrom(idEx.rs, exMem, memWb);
	assign fwdRtE = srcFrom(idEx.rt, exMem, memWb);

	// Decode sources produced by the instruction in EX or in MEM
	assign hitE = idEx.valid & idEx.ctrl.regWrite &
		((useRs & rsD == idEx.ctrl.dest) | (useRt & rtD == idEx.ctrl.dest));
	assign hitM = exMem.valid & exMem.ctrl.regWrite &
		((useRs & rsD == exMem.ctrl.dest) | (useRt & rtD == exMem.ctrl.dest));

	// A load consumer never reaches EX early, so this also covers execute
	assign stall = (hitE & (idEx.ctrl.memRead | isBranch)) | (hitM & exMem.ctrl.memRead);

endmodule

// File: hdl/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit import cpuPkg::*; #(
	parameter wordT resetVector = 32'hbfc00000
) (
	input  logic clk,
	input  logic arstN,
	input  logic stall,
	input  logic takeTarget,
	input  wordT target,
	input  wordT instRdata,
	output logic instEn,
	output wordT instAddr,
	output wordT instrD,
	output wordT pcD
);

	wordT pc;
	logic validD; // SRAM output holds a fetched word

	assign instEn   = !stall; // No fetch while IF/ID holds
	assign instAddr = pc;
	assign instrD   = validD ? instRdata : '0;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc     <= resetVector;
			validD <= 1'b0;
		end else if (!stall) begin
			pc     <= takeTarget ? target : pc + 32'd4;
			validD <= 1'b1;
		end
	end

	// Lines up with the SRAM read data
	always_ff @(posedge clk) begin
		if (!stall)
			pcD <= pc;
	end

endmodule

// File: hdl/decodeUnit.sv
`timescale 1ns/10ps

module decodeUnit import cpuPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  logic   stall,
	input  wordT   instrD,
	input  wordT   pcD,
	input  ctrlT   ctrlD,
	input  logic   isBranch,
	input  logic   isBne,
	input  logic   isJump,
	input  wordT   rsRf,
	input  wordT   rtRf,
	input  fwdSelE fwdRsD,
	input  fwdSelE fwdRtD,
	input  wordT   memFwd,
	input  wordT   wbFwd,
	output logic   takeTarget,
	output wordT   target,
	output idExT   idEx
);

	wordT rsVal;
	wordT rtVal;
	wordT imm;
	wordT pcPlus4;
	wordT branchTarget;
	wordT jumpTarget;
	logic zeroExt;
	logic branchTaken;

	assign rsVal = fwdOperand(fwdRsD, rsRf, memFwd, wbFwd);
	assign rtVal = fwdOperand(fwdRtD, rtRf, memFwd, wbFwd);

	// andi and ori are the only zero-extended immediates
	assign zeroExt = ctrlD.useImm & (ctrlD.aluOp == aluAnd || ctrlD.aluOp == aluOr);
	assign imm     = zeroExt ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

	assign pcPlus4      = pcD + 32'd4; // Delay slot address
	assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instrD[25:0], 2'b00};

	assign branchTaken = isBranch & ((rsVal == rtVal) ^ isBne);
	assign takeTarget  = branchTaken | isJump;
	assign target      = isJump ? jumpTarget : branchTarget;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else if (stall) begin
			idEx <= '0; // Bubble
		end else begin
			idEx <= '{
				valid: 1'b1,
				pc:    pcD,
				ctrl:  ctrlD,
				rsVal: rsVal,
				rtVal: rtVal,
				imm:   imm,
				rs:    instrD[25:21],
				rt:    instrD[20:16]
			};
		end
	end

endmodule

// File: hdl/executeUnit.sv
`timescale 1ns/10ps

module executeUnit import cpuPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  idExT       idEx,
	input  fwdSelE     fwdRsE,
	input  fwdSelE     fwdRtE,
	input  wordT       memFwd,
	input  wordT       wbFwd,
	output logic       dataEn,
	output logic [3:0] dataWen,
	output wordT       dataAddr,
	output wordT       dataWdata,
	output exMemT      exMem
);

	wordT opA;
	wordT rtFwd;
	wordT opB;
	wordT aluRes;

	assign opA   = fwdOperand(fwdRsE, idEx.rsVal, memFwd, wbFwd);
	assign rtFwd = fwdOperand(fwdRtE, idEx.rtVal, memFwd, wbFwd);
	assign opB   = idEx.ctrl.useImm ? idEx.imm : rtFwd;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluSub:  aluRes = opA - opB;
			aluAnd:  aluRes = opA & opB;
			aluOr:   aluRes = opA | opB;
			aluXor:  aluRes = opA ^ opB;
			aluSlt:  aluRes = {31'b0, $signed(opA) < $signed(opB)};
			aluSltu: aluRes = {31'b0, opA < opB};
			aluLui:  aluRes = {opB[15:0], 16'b0};
			default: aluRes = opA + opB; // Also the lw/sw address
		endcase
	end

	// Request goes out in EX, read data comes back in MEM
	assign dataEn    = 1'b1;
	assign dataWen   = {4{idEx.valid & idEx.ctrl.memWrite}};
	assign dataAddr  = {3'b000, aluRes[28:0]};
	assign dataWdata = rtFwd;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			exMem <= '0;
		else
			exMem <= '{
				valid:     idEx.valid,
				pc:        idEx.pc,
				ctrl:      idEx.ctrl,
				aluRes:    aluRes,
				storeData: rtFwd
			};
	end

endmodule

// File: hdl/memUnit.sv
`timescale 1ns/10ps

module memUnit import cpuPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  exMemT      exMem,
	input  wordT       dataRdata,
	output memWbT      memWb,
	output wordT       wbPc,
	output logic [3:0] wbRfWen,
	output regAddrT    wbRfWnum,
	output wordT       wbRfWdata
);

	wordT result;

	// SRAM answers the EX request in this cycle
	assign result = exMem.ctrl.memRead ? dataRdata : exMem.aluRes;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			memWb <= '0;
		else
			memWb <= '{
				valid:    exMem.valid,
				pc:       exMem.pc,
				regWrite: exMem.ctrl.regWrite,
				dest:     exMem.ctrl.dest,
				result:   result
			};
	end

	// Debug trace straight from MEM/WB
	assign wbPc      = memWb.pc;
	assign wbRfWen   = {4{memWb.valid & memWb.regWrite}};
	assign wbRfWnum  = memWb.dest;
	assign wbRfWdata = memWb.result;

endmodule

// File: hdl/cpuTop.sv
`timescale 1ns/10ps

module cpuTop import cpuPkg::*; #(
	parameter wordT resetVector = 32'hbfc00000
) (
	input  logic        clk,
	input  logic        arstN,
	// Instruction SRAM
	output logic        instEn,
	output wordT        instAddr,
	input  wordT        instRdata,
	// Data SRAM
	output logic        dataEn,
	output logic [3:0]  dataWen,
	output wordT        dataAddr,
	output wordT        dataWdata,
	input  wordT        dataRdata,
	// Writeback trace
	output wordT        wbPc,
	output logic [3:0]  wbRfWen,
	output regAddrT     wbRfWnum,
	output wordT        wbRfWdata
);

	wordT   instrD;
	wordT   pcD;
	ctrlT   ctrlD;
	logic   isBranch;
	logic   isBne;
	logic   isJump;
	fwdSelE fwdRsD;
	fwdSelE fwdRtD;
	fwdSelE fwdRsE;
	fwdSelE fwdRtE;
	logic   stall;
	logic   takeTarget;
	wordT   target;
	wordT   rsRf;
	wordT   rtRf;
	idExT   idEx;
	exMemT  exMem;
	memWbT  memWb;

	pipeCtrl u_pipeCtrl (
		.instrD(instrD), .idEx(idEx), .exMem(exMem), .memWb(memWb),
		.ctrlD(ctrlD), .isBranch(isBranch), .isBne(isBne), .isJump(isJump),
		.fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE),
		.stall(stall)
	);

	fetchUnit #(.resetVector(resetVector)) u_fetchUnit (
		.clk(clk), .arstN(arstN), .stall(stall), .takeTarget(takeTarget),
		.target(target), .instRdata(instRdata), .instEn(instEn),
		.instAddr(instAddr), .instrD(instrD), .pcD(pcD)
	);

	regFile u_regFile (
		.clk(clk), .arstN(arstN),
		.raddr1(instrD[25:21]), .raddr2(instrD[20:16]),
		.wen(memWb.valid & memWb.regWrite), .waddr(memWb.dest), .wdata(memWb.result),
		.rdata1(rsRf), .rdata2(rtRf)
	);

	decodeUnit u_decodeUnit (
		.clk(clk), .arstN(arstN), .stall(stall), .instrD(instrD), .pcD(pcD),
		.ctrlD(ctrlD), .isBranch(isBranch), .isBne(isBne), .isJump(isJump),
		.rsRf(rsRf), .rtRf(rtRf), .fwdRsD(fwdRsD), .fwdRtD(fwdRtD),
		.memFwd(exMem.aluRes), .wbFwd(memWb.result),
		.takeTarget(takeTarget), .target(target), .idEx(idEx)
	);

	executeUnit u_executeUnit (
		.clk(clk), .arstN(arstN), .idEx(idEx), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE),
		.memFwd(exMem.aluRes), .wbFwd(memWb.result),
		.dataEn(dataEn), .dataWen(dataWen), .dataAddr(dataAddr),
		.dataWdata(dataWdata), .exMem(exMem)
	);

	memUnit u_memUnit (
		.clk(clk), .arstN(arstN), .exMem(exMem), .dataRdata(dataRdata),
		.memWb(memWb), .wbPc(wbPc), .wbRfWen(wbRfWen), .wbRfWnum(wbRfWnum),
		.wbRfWdata(wbRfWdata)
	);

endmodule

// File: verif/cpuTb.sv
`timescale 1ns/10ps

module cpuTb import cpuPkg::*;;

	localparam wordT ResetVector = 32'hbfc00000;
	localparam int ResetCycles = 16;
	localparam int ProgLen = 200;
	localparam int ImemWords = 256;
	localparam int DmemWords = 64;
	localparam int TimeoutCycles = ResetCycles + 4 * ProgLen + 100; // At most two stalls each
	localparam logic [5:0] Functs [7] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
	localparam logic [5:0] ImmOps [5] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0f};

	typedef struct packed {
		logic       en;
		logic [3:0] wen;
		wordT       addr;
		wordT       wdata;
	} sramReqT;

	typedef struct packed {
		wordT    pc;
		regAddrT num;
		wordT    data;
	} wbEventT;

	logic       clk = 1'b0;
	logic       arstN = 1'b0;
	logic       instEn;
	wordT       instAddr;
	wordT       instRdata = '0;
	logic       dataEn;
	logic [3:0] dataWen;
	wordT       dataAddr;
	wordT       dataWdata;
	wordT       dataRdata = '0;
	wordT       wbPc;
	logic [3:0] wbRfWen;
	regAddrT    wbRfWnum;
	wordT       wbRfWdata;

	wordT    imem [ImemWords];
	wordT    dmem [DmemWords];
	wordT    modelMem [DmemWords];
	wbEventT expQ [$];
	sramReqT iReq = '0;
	sramReqT dReq = '0;
	int      checked = 0;
	int      mismatches = 0;
	int      otherErrs = 0;

	cpuTop #(.resetVector(ResetVector)) u_cpuTop (
		.clk(clk), .arstN(arstN),
		.instEn(instEn), .instAddr(instAddr), .instRdata(instRdata),
		.dataEn(dataEn), .dataWen(dataWen), .dataAddr(dataAddr),
		.dataWdata(dataWdata), .dataRdata(dataRdata),
		.wbPc(wbPc), .wbRfWen(wbRfWen), .wbRfWnum(wbRfWnum), .wbRfWdata(wbRfWdata)
	);

	always #4 clk = ~clk;

	function automatic wordT fillWord(wordT addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a50f1e;
	endfunction

	function automatic wordT fetchWord(wordT addr);
		wordT idx;
		idx = (addr - ResetVector) >> 2;
		return (idx < ImemWords) ? imem[idx] : '0; // Nops outside the program
	endfunction

	task automatic compareField(string name, wordT expected, wordT actual);
		assert (expected == actual) else begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic finishRun();
		$display("Writebacks checked: %0d, mismatches: %0d, other errors: %0d",
			checked, mismatches, otherErrs);
		if (mismatches == 0 && otherErrs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task automatic buildProgram();
		int      kind;
		int      off;
		logic    prevCtrl;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		wordT    tgt;
		prevCtrl = 1'b0;
		for (int i = 0; i < ImemWords; i++)
			imem[i] = '0;
		for (int i = 0; i < DmemWords; i++)
			dmem[i] = fillWord(32'(4 * i));
		for (int i = 0; i < ProgLen; i++) begin
			kind = int'($urandom % 10);
			if (prevCtrl && kind >= 8)
				kind = 0; // Delay slot never holds a branch
			rs  = 5'($urandom % 8); // Few registers, many dependences
			rt  = 5'($urandom % 8);
			rd  = 5'($urandom % 8);
			off = 1 + int'($urandom % 4);
			case (kind)
				0, 1, 2: imem[i] = {6'h00, rs, rt, rd, 5'd0, Functs[int'($urandom % 7)]};
				3, 4:    imem[i] = {ImmOps[int'($urandom % 5)], rs, rt, 16'($urandom)};
				5:       imem[i] = {6'h23, 5'd0, rt, 16'(4 * ($urandom % 64))};
				6:       imem[i] = {6'h2b, 5'd0, rt, 16'(4 * ($urandom % 64))};
				7:       imem[i] = ($urandom % 2 == 0) ? '0 : {6'h3f, 26'($urandom)};
				8:       imem[i] = {($urandom % 2 == 0) ? 6'h04 : 6'h05, rs, rt, 16'(off)};
				default: begin
					tgt     = ResetVector + 32'(4 * (i + 1 + off));
					imem[i] = {6'h02, tgt[27:2]};
				end
			endcase
			prevCtrl = (kind >= 8);
		end
	endtask

	// Architectural model with a branch delay slot
	task automatic runModel();
		wordT    regs [32];
		wordT    pc;
		wordT    npc;
		wordT    nnpc;
		wordT    ins;
		wordT    a;
		wordT    b;
		wordT    immS;
		wordT    res;
		wordT    ea;
		regAddrT dst;
		logic    wr;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < DmemWords; i++)
			modelMem[i] = fillWord(32'(4 * i));
		pc  = ResetVector;
		npc = ResetVector + 32'd4;
		while (((pc - ResetVector) >> 2) < ProgLen) begin
			ins  = fetchWord(pc);
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			immS = {{16{ins[15]}}, ins[15:0]};
			ea   = a + immS;
			dst  = ins[20:16];
			wr   = 1'b1;
			res  = '0;
			nnpc = npc + 32'd4;
			case (ins[31:26])
				6'h00: begin
					dst = ins[15:11];
					case (ins[5:0])
						6'h21:   res = a + b;
						6'h23:   res = a - b;
						6'h24:   res = a & b;
						6'h25:   res = a | b;
						6'h26:   res = a ^ b;
						6'h2a:   res = {31'b0, $signed(a) < $signed(b)};
						6'h2b:   res = {31'b0, a < b};
						default: wr = 1'b0;
					endcase
				end
				6'h09: res = ea;
				6'h0a: res = {31'b0, $signed(a) < $signed(immS)};
				6'h0c: res = a & {16'h0, ins[15:0]};
				6'h0d: res = a | {16'h0, ins[15:0]};
				6'h0f: res = {ins[15:0], 16'h0};
				6'h23: res = modelMem[ea[7:2]];
				6'h2b: begin
					modelMem[ea[7:2]] = b;
					wr = 1'b0;
				end
				6'h04, 6'h05: begin
					wr = 1'b0;
					if ((a == b) == (ins[31:26] == 6'h04))
						nnpc = npc + (immS << 2);
				end
				6'h02: begin
					wr   = 1'b0;
					nnpc = {npc[31:28], ins[25:0], 2'b00};
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				regs[dst] = res;
				expQ.push_back(wbEventT'{pc: pc, num: dst, data: res});
			end
			pc  = npc;
			npc = nnpc;
		end
	endtask

	// Both SRAMs answer the previous cycle's request
	always @(negedge clk) begin
		if (iReq.en)
			instRdata = fetchWord(iReq.addr);
		if (dReq.en) begin
			dataRdata = dmem[dReq.addr[7:2]];
			for (int b = 0; b < 4; b++)
				if (dReq.wen[b])
					dmem[dReq.addr[7:2]][8 * b +: 8] = dReq.wdata[8 * b +: 8];
		end
		#1; // Let the stall settle on the new instruction word
		iReq = '{en: instEn, wen: 4'h0, addr: instAddr, wdata: '0};
		dReq = '{en: dataEn, wen: dataWen, addr: dataAddr, wdata: dataWdata};
	end

	always @(negedge clk) begin
		wbEventT expEv;
		if (wbRfWen != 4'h0) begin
			assert (expQ.size() != 0) else begin
				$display("Unexpected writeback at %0t: pc %h, r%0d, data %h",
					$time, wbPc, wbRfWnum, wbRfWdata);
				otherErrs++;
			end
			if (expQ.size() != 0) begin
				expEv = expQ.pop_front();
				checked++;
				compareField("wbRfWen", 32'hf, 32'(wbRfWen));
				compareField("wbPc", expEv.pc, wbPc);
				compareField("wbRfWnum", 32'(expEv.num), 32'(wbRfWnum));
				compareField("wbRfWdata", expEv.data, wbRfWdata);
			end
		end
	end

	initial begin
		void'($urandom(31));
		buildProgram();
		runModel();
		repeat (ResetCycles) begin
			@(negedge clk);
			assert (wbRfWen == 4'h0 && dataWen == 4'h0) else begin
				$display("Write enable active during reset at %0t", $time);
				otherErrs++;
			end
		end
		arstN = 1'b1;
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk); // Catch stray writebacks
		for (int i = 0; i < DmemWords; i++)
			compareField($sformatf("dataMem[%0d]", i), modelMem[i], dmem[i]);
		finishRun();
	end

	initial begin
		repeat (TimeoutCycles) @(posedge clk);
		$display("Timeout after %0d cycles, %0d expected writebacks never appeared",
			TimeoutCycles, expQ.size());
		otherErrs++;
		finishRun();
	end

endmodule

// File: files.f
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/pipeCtrl.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/memUnit.sv
hdl/cpuTop.sv
verif/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -Mdir obj_dir -f files.f

out=$(./obj_dir/VcpuTb)
echo "$out"

# Fails the script when the pass line is missing
echo "$out" | grep -qx "No errors"
